//--- llink_st.f
+incdir+rtl
rtl/llink_st_pkg.sv
rtl/ll_auto_sync.sv
rtl/st_user_pack.sv
rtl/phy_lane_map.sv
rtl/st_nordy_master_top.sv
verification/tb_clk_gen.sv
verification/st_nordy_master_sva.sv
verification/tb_st_nordy_master.sv

//--- rtl/ll_auto_sync.sv
// Link bring-up: delays the online flags and drives the lane strobe and marker during alignment
module ll_auto_sync (
  input  logic                     clk_wr,
  input  logic                     rst_n,
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic                     tx_stb_userbit,
  input  logic                     tx_mrk_userbit,
  input  logic [15:0]              delay_x_value,
  input  logic [15:0]              delay_y_value,
  input  logic [15:0]              delay_z_value,
  output llink_st_pkg::link_sync_t sync
);

  logic [15:0] tx_cnt;
  logic [15:0] rx_cnt;
  logic [15:0] stb_cnt;
  logic        tx_dly_q;
  logic        rx_dly_q;
  logic        stb_q;
  logic        mrk_q;
  logic        rx_qual;
  logic        tx_hit;
  logic        rx_hit;
  logic        stb_hit;

  // Far side only counts once the local side is up
  assign rx_qual = rx_online & tx_dly_q;

  // Target reached on this edge; 17 bits so a full count cannot wrap
  assign tx_hit  = ({1'b0, tx_cnt} + 17'd1) >= {1'b0, delay_x_value};
  assign rx_hit  = ({1'b0, rx_cnt} + 17'd1) >= {1'b0, delay_y_value};
  // Zero period disables the strobe
  assign stb_hit = (delay_z_value != 16'd0) &&
                   (({1'b0, stb_cnt} + 17'd1) == {1'b0, delay_z_value});

  //////////////////////////////////////////////////
  // Online delays
  //////////////////////////////////////////////////

  // tx side: count cycles with tx_online held high
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_cnt   <= 16'd0;
      tx_dly_q <= 1'b0;
    end else if (!tx_online) begin
      tx_cnt   <= 16'd0;
      tx_dly_q <= 1'b0;
    end else if (!tx_dly_q) begin
      if (tx_hit) tx_dly_q <= 1'b1;
      else        tx_cnt   <= tx_cnt + 16'd1;
    end
  end

  // rx side, same scheme on the qualified flag
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt   <= 16'd0;
      rx_dly_q <= 1'b0;
    end else if (!rx_qual) begin
      rx_cnt   <= 16'd0;
      rx_dly_q <= 1'b0;
    end else if (!rx_dly_q) begin
      if (rx_hit) rx_dly_q <= 1'b1;
      else        rx_cnt   <= rx_cnt + 16'd1;
    end
  end

  //////////////////////////////////////////////////
  // Strobe and marker
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      stb_cnt <= 16'd0;
      stb_q   <= 1'b0;
      mrk_q   <= 1'b0;
    end else if (!tx_online) begin
      stb_cnt <= 16'd0;
      stb_q   <= 1'b0;
      mrk_q   <= 1'b0;
    end else if (tx_dly_q) begin
      // Link up, user bits pass through
      stb_q <= tx_stb_userbit;
      mrk_q <= tx_mrk_userbit;
    end else begin
      // Alignment: periodic strobe, no marker
      mrk_q <= 1'b0;
      if (stb_hit) begin
        stb_cnt <= 16'd0;
        stb_q   <= 1'b1;
      end else begin
        stb_cnt <= stb_cnt + 16'd1;
        stb_q   <= 1'b0;
      end
    end
  end

  assign sync = '{tx_online_delay: tx_dly_q, rx_online_delay: rx_dly_q,
                  stb: stb_q, mrk: mrk_q};

endmodule

//--- rtl/llink_st_cfg.svh
// Width and lane position macros for the stream transmit link, included by the package and RTL
`ifndef LLINK_ST_CFG_SVH
`define LLINK_ST_CFG_SVH

// User stream widths
`define LLST_DATA_W 64
`define LLST_KEEP_W 8

// Packed word: tdata, tkeep, tlast, tvalid
`define LLST_WORD_W 74

// One PHY lane beat
`define LLST_PHY_W 80

// Reserved lane positions
// Strobe, same in both modes
`define LLST_STB_BIT 1
// Marker, both modes
`define LLST_MRK_BIT_HI 79
// Extra marker copy, Gen1 only
`define LLST_MRK_BIT_LO 39

`endif

//--- rtl/llink_st_pkg.sv
// Shared types of the stream transmit link; compile first, modules reference it by name
`include "llink_st_cfg.svh"

package llink_st_pkg;

  //////////////////////////////////////////////////
  // Stream word
  //////////////////////////////////////////////////

  // Packed user beat as carried on the lane
  // tdata sits at bit 0, tvalid at the top
  typedef struct packed {
    logic                    tvalid;
    // End of packet
    logic                    tlast;
    // One bit per data byte
    logic [`LLST_KEEP_W-1:0] tkeep;
    // Payload, unkept bytes already zeroed
    logic [`LLST_DATA_W-1:0] tdata;
  } st_word_t;

  //////////////////////////////////////////////////
  // Bring-up status
  //////////////////////////////////////////////////

  // Outputs of the bring-up block
  typedef struct packed {
    // Local side ready to send data
    logic tx_online_delay;
    // Far side seen online, beats may be accepted
    logic rx_online_delay;
    // Strobe bit for the lane
    logic stb;
    // Marker bit for the lane
    logic mrk;
  } link_sync_t;

endpackage

//--- rtl/phy_lane_map.sv
// Lane mapper: spreads the stream word around the strobe and marker bits, registers the PHY beat
`include "llink_st_cfg.svh"

module phy_lane_map (
  input  logic                     clk_wr,
  input  logic                     rst_n,
  input  logic                     m_gen2_mode,
  input  llink_st_pkg::link_sync_t sync,
  input  llink_st_pkg::st_word_t   word,
  output logic [`LLST_PHY_W-1:0]   tx_phy0
);

  logic [`LLST_WORD_W-1:0] word_bits;
  logic [`LLST_PHY_W-1:0]  beat_d;

  // Data blanked until the local side is online
  assign word_bits = sync.tx_online_delay ? word : '0;

  //////////////////////////////////////////////////
  // Beat layout
  //////////////////////////////////////////////////

  // Gen2 reserves 1 and 79
  // Gen1 also reserves 39 for a second marker copy
  // Word bits fill the rest from bit 0 up
  always_comb begin
    int unsigned idx;
    logic        rsvd;

    beat_d = '0;
    idx    = 0;
    for (int p = 0; p < `LLST_PHY_W; p++) begin
      rsvd = (p == `LLST_STB_BIT) || (p == `LLST_MRK_BIT_HI) ||
             (!m_gen2_mode && (p == `LLST_MRK_BIT_LO));
      // Positions past the last word bit stay 0
      if (!rsvd && (idx < `LLST_WORD_W)) begin
        beat_d[p] = word_bits[idx];
        idx       = idx + 1;
      end
    end

    // Sync bits go out even while offline
    beat_d[`LLST_STB_BIT]    = sync.stb;
    beat_d[`LLST_MRK_BIT_HI] = sync.mrk;
    if (!m_gen2_mode) begin
      beat_d[`LLST_MRK_BIT_LO] = sync.mrk;
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  // One cycle to the lane
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= beat_d;
    end
  end

endmodule

//--- rtl/st_nordy_master_top.sv
// Top of the stream transmit link: bring-up, packing and lane mapping onto one 80-bit lane
`include "llink_st_cfg.svh"

module st_nordy_master_top (
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic                    m_gen2_mode,
  input  logic                    tx_stb_userbit,
  input  logic                    tx_mrk_userbit,

  // Bring-up delays and strobe period
  input  logic [15:0]             delay_x_value,
  input  logic [15:0]             delay_y_value,
  input  logic [15:0]             delay_z_value,

  // User stream, no ready
  input  logic [`LLST_KEEP_W-1:0] user_tkeep,
  input  logic [`LLST_DATA_W-1:0] user_tdata,
  input  logic                    user_tlast,
  input  logic                    user_tvalid,

  // PHY lane and debug
  output logic [`LLST_PHY_W-1:0]  tx_phy0,
  output logic [31:0]             tx_st_debug_status
);
  import llink_st_pkg::*;

  link_sync_t  sync;
  st_word_t    word;
  logic [15:0] beat_count;

  //////////////////////////////////////////////////
  // Bring-up
  //////////////////////////////////////////////////

  ll_auto_sync ll_auto_sync_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_mrk_userbit (tx_mrk_userbit),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .sync           (sync)
  );

  //////////////////////////////////////////////////
  // User packing
  //////////////////////////////////////////////////

  st_user_pack st_user_pack_i (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .user_tvalid (user_tvalid),
    .user_tlast  (user_tlast),
    .user_tkeep  (user_tkeep),
    .user_tdata  (user_tdata),
    .sync        (sync),
    .word        (word),
    .beat_count  (beat_count)
  );

  //////////////////////////////////////////////////
  // Lane mapping
  //////////////////////////////////////////////////

  phy_lane_map phy_lane_map_i (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .m_gen2_mode (m_gen2_mode),
    .sync        (sync),
    .word        (word),
    .tx_phy0     (tx_phy0)
  );

  // Debug word: online flags at 19:18, beat count at 15:0
  assign tx_st_debug_status = {12'h000, sync.tx_online_delay, sync.rx_online_delay,
                               2'b00, beat_count};

endmodule

//--- rtl/st_user_pack.sv
// Packs the user stream into the lane word and counts beats actually sent
`include "llink_st_cfg.svh"

module st_user_pack (
  input  logic                      clk_wr,
  input  logic                      rst_n,
  input  logic                      user_tvalid,
  input  logic                      user_tlast,
  input  logic [`LLST_KEEP_W-1:0]   user_tkeep,
  input  logic [`LLST_DATA_W-1:0]   user_tdata,
  input  llink_st_pkg::link_sync_t  sync,
  output llink_st_pkg::st_word_t    word,
  output logic [15:0]               beat_count
);

  logic [`LLST_DATA_W-1:0] data_masked;
  logic                    word_valid;

  // Zero each byte whose keep bit is clear
  always_comb begin
    for (int b = 0; b < `LLST_KEEP_W; b++) begin
      data_masked[8*b +: 8] = user_tkeep[b] ? user_tdata[8*b +: 8] : 8'h00;
    end
  end

  // Beats offered before the far side is online are dropped
  assign word_valid = user_tvalid & sync.rx_online_delay;

  assign word = '{tvalid: word_valid, tlast: user_tlast,
                  tkeep: user_tkeep, tdata: data_masked};

  // Debug count of sent beats, free-running wrap
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      beat_count <= 16'd0;
    end else if (word_valid) begin
      beat_count <= beat_count + 16'd1;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_st_nordy_master -f llink_st.f

out=$(./obj_dir/Vtb_st_nordy_master) || true
echo "$out"
if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

//--- verification/st_nordy_master_sva.sv
// Concurrent checks on the lane beat and debug word, bound into the transmit top level
`include "llink_st_cfg.svh"

module st_nordy_master_sva (
  input logic                   clk_wr,
  input logic                   rst_n,
  input logic                   m_gen2_mode,
  input logic [`LLST_PHY_W-1:0] tx_phy0,
  input logic [31:0]            tx_st_debug_status
);
  timeunit 1ns;
  timeprecision 1ps;

  // Strobe and marker positions per mode
  localparam logic [`LLST_PHY_W-1:0] SYNC_G2 =
    (80'd1 << `LLST_STB_BIT) | (80'd1 << `LLST_MRK_BIT_HI);
  localparam logic [`LLST_PHY_W-1:0] SYNC_G1 = SYNC_G2 | (80'd1 << `LLST_MRK_BIT_LO);

  // Beat was built from last cycle's state, so look back one edge
  a_data_blank: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !$past(tx_st_debug_status[19]) |->
      ((tx_phy0 & ~($past(m_gen2_mode) ? SYNC_G2 : SYNC_G1)) == '0))
    else $error("lane data present while the tx side was offline");

  // Reserved debug bits
  a_debug_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (tx_st_debug_status[31:20] == '0) && (tx_st_debug_status[17:16] == '0))
    else $error("reserved debug status bits set");

  // Far side never up ahead of the local side
  a_online_order: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !(tx_st_debug_status[18] && !tx_st_debug_status[19]))
    else $error("rx online flag high while tx online flag low");

endmodule

bind st_nordy_master_top st_nordy_master_sva st_nordy_master_sva_i (
  .clk_wr             (clk_wr),
  .rst_n              (rst_n),
  .m_gen2_mode        (m_gen2_mode),
  .tx_phy0            (tx_phy0),
  .tx_st_debug_status (tx_st_debug_status)
);

//--- verification/tb_clk_gen.sv
// Free-running 8 ns clock and a 5-cycle active-low reset for the transmit link testbench
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held low over the first five rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- verification/tb_st_nordy_master.sv
// Top-level testbench that checks link bring-up, strobes and random traffic against a lane model
`include "llink_st_cfg.svh"

module tb_st_nordy_master;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 100;

  logic                    clk_wr;
  logic                    rst_n;
  logic                    tx_online, rx_online, m_gen2_mode;
  logic                    tx_stb_userbit, tx_mrk_userbit;
  logic [15:0]             delay_x_value, delay_y_value, delay_z_value;
  logic [`LLST_KEEP_W-1:0] user_tkeep;
  logic [`LLST_DATA_W-1:0] user_tdata;
  logic                    user_tlast, user_tvalid;
  logic [`LLST_PHY_W-1:0]  tx_phy0;
  logic [31:0]             tx_st_debug_status;

  // Lane model state as it will be after the next rise
  logic                    ref_tx_up, ref_rx_up, ref_stb, ref_mrk;
  int                      ref_tx_run, ref_rx_run, ref_align;
  logic [15:0]             ref_beats;
  logic [`LLST_PHY_W-1:0]  exp_beat;
  logic                    exp_armed;
  string                   test_name;
  int                      errors;
  int                      checks;

  tb_clk_gen clk_gen_i (.clk(clk_wr), .rst_n(rst_n));

  st_nordy_master_top st_nordy_master_top_i (.*);

  //////////////////////////////////////////////////
  // Reference beat
  //////////////////////////////////////////////////

  function automatic logic [79:0] build_beat(
    input logic [63:0] tdata, input logic [7:0] tkeep, input logic tlast,
    input logic tvalid, input logic rx_up, input logic tx_up,
    input logic stb, input logic mrk, input logic gen2);
    logic [63:0] data;
    logic [73:0] w;
    logic [79:0] beat;
    // Byte mask from keep
    data = tdata & {{8{tkeep[7]}}, {8{tkeep[6]}}, {8{tkeep[5]}}, {8{tkeep[4]}},
                    {8{tkeep[3]}}, {8{tkeep[2]}}, {8{tkeep[1]}}, {8{tkeep[0]}}};
    w = tx_up ? {tvalid & rx_up, tlast, tkeep, data} : 74'd0;
    beat    = '0;
    beat[0] = w[0];
    if (gen2) begin
      beat[74:2] = w[73:1];
    end else begin
      // Gen1 skips bit 39 as well
      beat[38:2]  = w[37:1];
      beat[75:40] = w[73:38];
      beat[39]    = mrk;
    end
    beat[1]  = stb;
    beat[79] = mrk;
    return beat;
  endfunction

  //////////////////////////////////////////////////
  // Compare process and lane model
  //////////////////////////////////////////////////

  always @(negedge clk_wr) begin
    int   tx_run_n;
    int   rx_run_n;
    logic rx_qual;
    if (!rst_n) begin
      {ref_tx_up, ref_rx_up, ref_stb, ref_mrk, exp_armed} = '0;
      {ref_tx_run, ref_rx_run, ref_align} = '0;
      ref_beats = '0;
    end else begin
      if (exp_armed) begin
        checks++;
        assert (tx_phy0 == exp_beat) else begin
          $display("CHECK FAILED %s tx_phy0: expected %h actual %h", test_name, exp_beat, tx_phy0);
          errors++;
        end
        assert (tx_st_debug_status[15:0] == ref_beats) else begin
          $display("CHECK FAILED %s beat count: expected %0d actual %0d", test_name,
                   ref_beats, tx_st_debug_status[15:0]);
          errors++;
        end
      end
      // Expected beat for the next rise
      exp_beat  = build_beat(user_tdata, user_tkeep, user_tlast, user_tvalid, ref_rx_up,
                             ref_tx_up, ref_stb, ref_mrk, m_gen2_mode);
      exp_armed = 1'b1;
      if (user_tvalid && ref_rx_up) begin
        ref_beats = ref_beats + 16'd1;
      end
      // Consecutive-cycle runs behind each online delay
      tx_run_n = tx_online ? ref_tx_run + 1 : 0;
      rx_qual  = rx_online & ref_tx_up;
      rx_run_n = rx_qual ? ref_rx_run + 1 : 0;
      if (!tx_online) begin
        ref_align = 0;
        ref_stb   = 1'b0;
        ref_mrk   = 1'b0;
      end else if (ref_tx_up) begin
        ref_stb = tx_stb_userbit;
        ref_mrk = tx_mrk_userbit;
      end else begin
        // Alignment strobe every z-th cycle
        ref_align = ref_align + 1;
        ref_stb   = (delay_z_value != 16'd0) && (ref_align % int'(delay_z_value) == 0);
        ref_mrk   = 1'b0;
      end
      ref_rx_up  = rx_qual && (ref_rx_up || rx_run_n >= int'(delay_y_value));
      ref_tx_up  = tx_online && (ref_tx_up || tx_run_n >= int'(delay_x_value));
      ref_tx_run = tx_run_n;
      ref_rx_run = rx_run_n;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_count(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // Counts rising edges until a debug bit reaches the level
  task automatic wait_debug_bit(input logic [4:0] idx, input logic level, output int cycles);
    cycles = 0;
    do begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      cycles++;
    end while (tx_st_debug_status[idx] !== level && cycles < WAIT_LIMIT);
    if (tx_st_debug_status[idx] !== level) begin
      $display("Timeout: debug bit %0d did not reach %0b in %0d cycles", idx, level, WAIT_LIMIT);
      errors++;
    end
  endtask

  // Random beat on the next rise
  task automatic drive_beat(input logic force_valid);
    logic [31:0] r;
    r = $urandom();
    @(posedge clk_wr);
    user_tdata     <= {$urandom(), $urandom()};
    user_tkeep     <= r[7:0];
    user_tlast     <= r[8];
    user_tvalid    <= force_valid | r[9];
    tx_stb_userbit <= r[10];
    tx_mrk_userbit <= r[11];
  endtask

  task automatic end_test(input int errors_before);
    $display("test %-12s done, %0d errors", test_name, errors - errors_before);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int n;
    int prev;
    int pulses;
    int err0;
    {tx_online, rx_online, m_gen2_mode, tx_stb_userbit, tx_mrk_userbit} = '0;
    {delay_x_value, delay_y_value, delay_z_value} = '0;
    {user_tkeep, user_tdata, user_tlast, user_tvalid} = '0;
    {errors, checks} = '0;
    void'($urandom(61));
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clk_wr);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      errors++;
    end

    // Online delays rise after their counts and fall one cycle after the input
    test_name = "bring_up";
    err0      = errors;
    @(posedge clk_wr);
    delay_x_value <= 16'd6;
    delay_y_value <= 16'd4;
    tx_online     <= 1'b1;
    rx_online     <= 1'b1;
    wait_debug_bit(5'd19, 1'b1, n);
    check_count("tx delay rise", 6, n);
    wait_debug_bit(5'd18, 1'b1, n);
    check_count("rx delay rise", 4, n);
    @(posedge clk_wr);
    rx_online <= 1'b0;
    wait_debug_bit(5'd18, 1'b0, n);
    check_count("rx delay fall", 1, n);
    @(posedge clk_wr);
    tx_online <= 1'b0;
    wait_debug_bit(5'd19, 1'b0, n);
    check_count("tx delay fall", 1, n);
    end_test(err0);

    // Strobe every third cycle and nothing else on the lane
    test_name = "align_strobe";
    err0      = errors;
    @(posedge clk_wr);
    delay_x_value <= 16'd40;
    delay_z_value <= 16'd3;
    tx_online     <= 1'b1;
    prev   = -1;
    pulses = 0;
    for (int c = 0; c < 30; c++) begin
      drive_beat(1'b0);
      @(negedge clk_wr);
      assert ((tx_phy0 & ~80'h2) == '0) else begin
        $display("CHECK FAILED %s lane: expected 0 actual %h", test_name, tx_phy0 & ~80'h2);
        errors++;
      end
      if (tx_phy0[`LLST_STB_BIT]) begin
        if (prev >= 0) begin
          check_count("strobe period", 3, c - prev);
        end
        prev = c;
        pulses++;
      end
    end
    check_count("strobe pulses", 9, pulses);
    end_test(err0);

    // Random traffic in the Gen2 layout
    test_name = "gen2_stream";
    err0      = errors;
    @(posedge clk_wr);
    delay_x_value <= 16'd2;
    delay_y_value <= 16'd2;
    m_gen2_mode   <= 1'b1;
    rx_online     <= 1'b1;
    wait_debug_bit(5'd18, 1'b1, n);
    repeat (200) drive_beat(1'b0);
    end_test(err0);

    // Random traffic in the Gen1 layout with the second marker copy
    test_name = "gen1_stream";
    err0      = errors;
    @(posedge clk_wr);
    m_gen2_mode <= 1'b0;
    repeat (200) drive_beat(1'b0);
    end_test(err0);

    // Beats while the far side is down are dropped and not counted
    test_name = "beat_count";
    err0      = errors;
    @(posedge clk_wr);
    m_gen2_mode <= 1'b1;
    repeat (20) drive_beat(1'b1);
    @(posedge clk_wr);
    rx_online <= 1'b0;
    repeat (10) drive_beat(1'b1);
    @(posedge clk_wr);
    rx_online <= 1'b1;
    wait_debug_bit(5'd18, 1'b1, n);
    repeat (20) drive_beat(1'b1);
    @(posedge clk_wr);
    user_tvalid <= 1'b0;
    repeat (2) @(negedge clk_wr);
    #1;
    end_test(err0);

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
